// File: flist.f
synth_pkg.sv
uart_rx.sv
midi_decoder.sv
pulse_gen.sv
stereo_dac.sv
synth_top.sv
synth_chk.sv
tb_synth.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the pulse synth testbench
# the run fails when the log holds the fail message

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_synth -f flist.f \
    && ./obj_dir/Vtb_synth > sim.log 2>&1 \
    || echo "*** FAILED ***" >> sim.log
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// File: tb_synth.sv
// tb_synth
// testbench for the MIDI pulse synth slice
// drives MIDI frames on rx, tracks the expected voice state
// and checks sample words, pitch and DAC density

`timescale 1ns/1ps
`default_nettype none

module tb_synth
    import synth_pkg::*;
();

    localparam int bit_cyc   = 16;
    localparam int frame_cyc = 10 * bit_cyc;
    localparam int smpl_cyc  = 64;
    // frames sent and samples waited over all tests
    localparam int n_frames    = 32;
    localparam int n_smpls     = 1074;
    localparam int timeout_cyc = (n_frames * frame_cyc + n_smpls * smpl_cyc + 8) * 3 / 2;

    logic clk;
    logic rst;
    logic rx;
    logic dac_out_l;
    logic dac_out_r;
    logic smpl_rdy;
    logic signed [smpl_w-1:0] smpl_l;
    logic signed [smpl_w-1:0] smpl_r;

    // expected voice state
    int m_note;
    int m_vel;
    int m_pan;
    bit m_gate;

    int          err_cnt;
    int          cyc_cnt;
    logic [31:0] lfsr_q;
    bit          pos_seen;
    bit          neg_seen;

    synth_top #(
        .clk_freq  (1_000_000),
        .baud_rate (62_500),
        .smpl_rate (15_625),
        .midi_ch   (4'd3)
    ) synth_top_i (
        .clk       (clk       ),
        .rst       (rst       ),
        .rx        (rx        ),
        .dac_out_l (dac_out_l ),
        .dac_out_r (dac_out_r ),
        .smpl_rdy  (smpl_rdy  ),
        .smpl_l    (smpl_l    ),
        .smpl_r    (smpl_r    )
    );

    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= timeout_cyc) begin
            $display("timeout: stimulus still running after %0d cycles", cyc_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            repeat (bit_cyc) begin
                @(posedge clk);
                rx <= frame[i];
            end
        end
    endtask

    task automatic send_msg(input logic [7:0] status, input int d0, input int d1);
        send_byte(status);
        send_byte(8'(d0));
        send_byte(8'(d1));
    endtask

    // outputs read on the falling edge
    task automatic wait_sample();
        @(negedge clk);
        while (!smpl_rdy) @(negedge clk);
    endtask

    // one sample of margin after the message lands
    task automatic settle();
        wait_sample();
        wait_sample();
    endtask

    // ------------------------------------------------------------------
    // expected values
    // ------------------------------------------------------------------
    // amplitude times pan gain, shifted right by 7
    function automatic int pan_mag(input int vel, input int gain);
        return ((vel << amp_shift) * gain) >>> 7;
    endfunction

    function automatic int mag(input int v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic check_voice(input int n);
        int got_l;
        int got_r;
        int exp_l;
        int exp_r;
        for (int i = 0; i < n; i++) begin
            wait_sample();
            got_l = smpl_l;
            got_r = smpl_r;
            exp_l = m_gate ? pan_mag(m_vel, 127 - m_pan) : 0;
            exp_r = m_gate ? pan_mag(m_vel, m_pan) : 0;
            assert (mag(got_l) == exp_l) else begin
                $display("[FAIL] smpl_l got %h exp magnitude %h", smpl_l, exp_l);
                err_cnt++;
            end
            assert (mag(got_r) == exp_r) else begin
                $display("[FAIL] smpl_r got %h exp magnitude %h", smpl_r, exp_r);
                err_cnt++;
            end
            // both sides follow one raw wave
            assert (!(got_l > 0 && got_r < 0) && !(got_l < 0 && got_r > 0)) else begin
                $display("left and right samples have opposite signs");
                err_cnt++;
            end
            if (got_l > 0) pos_seen = 1'b1;
            if (got_l < 0) neg_seen = 1'b1;
        end
    endtask

    // sign changes of smpl_l over 256 sample intervals
    task automatic count_crossings(output int cnt);
        logic prev_neg;
        cnt = 0;
        wait_sample();
        prev_neg = smpl_l[smpl_w-1];
        repeat (256) begin
            wait_sample();
            if (smpl_l[smpl_w-1] != prev_neg) cnt++;
            prev_neg = smpl_l[smpl_w-1];
        end
    endtask

    // two changes per period, 2^24 phase per period
    task automatic check_pitch(input int note, input int cnt);
        longint inc;
        longint dev;
        inc = longint'(note_inc[note % 12]) << (note / 12);
        dev = longint'(cnt) * (longint'(1) << phase_w) - 512 * inc;
        assert (dev <= (longint'(1) << phase_w) && dev >= -(longint'(1) << phase_w)) else begin
            $display("[FAIL] smpl_l sign changes %h exp %h", cnt, (512 * inc) >> phase_w);
            err_cnt++;
        end
    endtask

    // ones over one 64-cycle window against (s + 2^17) / 2^18
    task automatic check_dac_window();
        int     s_l;
        int     s_r;
        int     ones_l;
        int     ones_r;
        longint dev_l;
        longint dev_r;
        wait_sample();
        s_l    = smpl_l;
        s_r    = smpl_r;
        ones_l = 0;
        ones_r = 0;
        // latch edge, then one cycle for the accumulator
        @(negedge clk);
        repeat (smpl_cyc) begin
            @(negedge clk);
            ones_l += int'(dac_out_l);
            ones_r += int'(dac_out_r);
        end
        dev_l = longint'(ones_l) * 262144 - 64 * (longint'(s_l) + 131072);
        dev_r = longint'(ones_r) * 262144 - 64 * (longint'(s_r) + 131072);
        assert (dev_l <= 262144 && dev_l >= -262144) else begin
            $display("[FAIL] dac_out_l ones %h for smpl_l %h", ones_l, s_l);
            err_cnt++;
        end
        assert (dev_r <= 262144 && dev_r >= -262144) else begin
            $display("[FAIL] dac_out_r ones %h for smpl_r %h", ones_r, s_r);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        int r;
        int note_lo;
        int cnt_lo;
        int cnt_hi;
        clk     = 1'b0;
        rst     = 1'b1;
        rx      = 1'b1;
        err_cnt = 0;
        cyc_cnt = 0;
        lfsr_q  = 32'h586e;
        m_note  = 0;
        m_vel   = 0;
        m_pan   = int'(pan_default);
        m_gate  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // silent before any note, then note-on at default pan
        check_voice(4);
        take_bits(5, r);
        m_note = 60 + r % 24;
        take_bits(6, r);
        m_vel  = 64 + r;
        m_gate = 1'b1;
        send_msg(8'h93, m_note, m_vel);
        settle();
        pos_seen = 1'b0;
        neg_seen = 1'b0;
        check_voice(200);
        assert (pos_seen && neg_seen) else begin
            $display("square wave never changed sign while the note was held");
            err_cnt++;
        end

        // running status, with a realtime clock byte in between
        take_bits(5, r);
        m_note = 60 + r % 24;
        take_bits(6, r);
        m_vel = 64 + r;
        send_byte(8'hf8);
        send_byte(8'(m_note));
        send_byte(8'(m_vel));
        settle();
        check_voice(64);
        take_bits(6, r);
        m_pan = 16 + r;
        send_msg(8'hb3, int'(cc_pan), m_pan);
        settle();
        check_voice(64);

        // channel 5 is filtered out
        send_msg(8'h95, 40, 100);
        send_msg(8'hb5, int'(cc_pan), 0);
        settle();
        check_voice(64);

        // release of another note keeps the sound
        send_msg(8'h83, m_note ^ 1, 64);
        settle();
        check_voice(64);
        send_msg(8'h93, m_note, 0);
        m_gate = 1'b0;
        settle();
        check_voice(32);
        send_msg(8'h93, m_note, m_vel);
        m_gate = 1'b1;
        settle();
        check_voice(16);
        send_msg(8'h83, m_note, 64);
        m_gate = 1'b0;
        settle();
        check_voice(16);

        // pitch, one octave apart
        take_bits(4, r);
        note_lo = 72 + r % 12;
        m_note  = note_lo;
        m_gate  = 1'b1;
        send_msg(8'h93, note_lo, m_vel);
        settle();
        count_crossings(cnt_lo);
        check_pitch(note_lo, cnt_lo);
        m_note = note_lo + 12;
        send_byte(8'(m_note));
        send_byte(8'(m_vel));
        settle();
        count_crossings(cnt_hi);
        check_pitch(m_note, cnt_hi);
        assert (cnt_hi - 2 * cnt_lo <= 2 && cnt_hi - 2 * cnt_lo >= -2) else begin
            $display("[FAIL] smpl_l sign changes %h exp twice %h", cnt_hi, cnt_lo);
            err_cnt++;
        end

        // DAC density with the upper note held
        repeat (8) check_dac_window();

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: synth_chk.sv
// synth_chk
// bound assertions on the pulse synth top level
// reset state, sample strobe spacing, sample hold and peak range

`timescale 1ns/1ps
`default_nettype none

module synth_chk
    import synth_pkg::*;
(
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     byte_strb,
    input wire logic                     midi_rdy,
    input wire logic                     smpl_rdy,
    input wire logic signed [smpl_w-1:0] smpl_l,
    input wire logic signed [smpl_w-1:0] smpl_r,
    input wire logic                     dac_out_l,
    input wire logic                     dac_out_r
);

    // cycles since the last sample strobe
    logic [7:0] gap_cnt;
    logic       seen_strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            gap_cnt   <= '0;
            seen_strb <= 1'b0;
        end else if (smpl_rdy) begin
            gap_cnt   <= '0;
            seen_strb <= 1'b1;
        end else if (gap_cnt != 8'hff) begin
            gap_cnt <= gap_cnt + 8'd1;
        end
    end

    // ------------------------------------------------------------------
    // reset state
    // ------------------------------------------------------------------
    a_idle_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |=> !smpl_rdy && !midi_rdy && !byte_strb
            && smpl_l == '0 && smpl_r == '0 && !dac_out_l && !dac_out_r)
        else $error("outputs not idle while reset is held");

    // ------------------------------------------------------------------
    // sample strobe and sample words
    // ------------------------------------------------------------------
    a_strb_width: assert property (@(posedge clk) disable iff (rst)
        smpl_rdy |=> !smpl_rdy)
        else $error("smpl_rdy held high for more than one cycle");

    // one sample period is 64 cycles
    a_strb_gap: assert property (@(posedge clk) disable iff (rst)
        smpl_rdy && seen_strb |-> gap_cnt >= 8'd63)
        else $error("smpl_rdy strobes closer than one sample period");

    a_smpl_hold: assert property (@(posedge clk) disable iff (rst)
        !smpl_rdy |-> $stable(smpl_l) && $stable(smpl_r))
        else $error("sample words changed between strobes");

    // velocity 127 at full pan is the peak
    a_smpl_peak: assert property (@(posedge clk) disable iff (rst)
        smpl_l >= -130048 && smpl_l <= 130048 && smpl_r >= -130048 && smpl_r <= 130048)
        else $error("sample magnitude above the velocity peak");

endmodule

bind synth_top synth_chk synth_chk_i (
    .clk       (clk       ),
    .rst       (rst       ),
    .byte_strb (byte_strb ),
    .midi_rdy  (midi_rdy  ),
    .smpl_rdy  (smpl_rdy  ),
    .smpl_l    (smpl_l    ),
    .smpl_r    (smpl_r    ),
    .dac_out_l (dac_out_l ),
    .dac_out_r (dac_out_r )
);

`default_nettype wire

// File: synth_top.sv
// synth_top
// MIDI pulse synth slice: UART rx, MIDI decode, pulse voice, stereo DAC
// sample pair and strobe also leave as a monitor tap

`timescale 1ns/1ps
`default_nettype none

module synth_top
    import synth_pkg::*;
#(
    parameter int         clk_freq  = 100_000_000,
    parameter int         baud_rate = 38400,
    parameter int         smpl_rate = 48000,
    parameter logic [3:0] midi_ch   = 4'd0
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     rx,
    output logic                          dac_out_l,
    output logic                          dac_out_r,
    output logic                          smpl_rdy,
    output logic signed [smpl_w-1:0]      smpl_l,
    output logic signed [smpl_w-1:0]      smpl_r
);

    // receiver to decoder
    logic       byte_strb;
    logic [7:0] byte_data;

    // decoder to voice
    logic       midi_rdy;
    midi_cmd_e  midi_cmd;
    logic [6:0] midi_data0;
    logic [6:0] midi_data1;

    uart_rx #(.clk_freq(clk_freq), .baud_rate(baud_rate)) uart_rx_inst (
        .clk       (clk       ),
        .rst       (rst       ),
        .rx        (rx        ),
        .byte_strb (byte_strb ),
        .byte_data (byte_data )
    );

    midi_decoder #(.midi_ch(midi_ch)) midi_decoder_inst (
        .clk        (clk        ),
        .rst        (rst        ),
        .byte_strb  (byte_strb  ),
        .byte_data  (byte_data  ),
        .midi_rdy   (midi_rdy   ),
        .midi_cmd   (midi_cmd   ),
        .midi_data0 (midi_data0 ),
        .midi_data1 (midi_data1 )
    );

    pulse_gen #(.clk_freq(clk_freq), .smpl_rate(smpl_rate)) pulse_gen_inst (
        .clk        (clk        ),
        .rst        (rst        ),
        .midi_rdy   (midi_rdy   ),
        .midi_cmd   (midi_cmd   ),
        .midi_data0 (midi_data0 ),
        .midi_data1 (midi_data1 ),
        .smpl_rdy   (smpl_rdy   ),
        .smpl_l     (smpl_l     ),
        .smpl_r     (smpl_r     )
    );

    // sample tap above feeds the DAC as well
    stereo_dac stereo_dac_inst (
        .clk       (clk       ),
        .rst       (rst       ),
        .smpl_rdy  (smpl_rdy  ),
        .smpl_l    (smpl_l    ),
        .smpl_r    (smpl_r    ),
        .dac_out_l (dac_out_l ),
        .dac_out_r (dac_out_r )
    );

endmodule

`default_nettype wire

// File: stereo_dac.sv
// stereo_dac
// two first-order sigma-delta modulators, the result stage
// each channel latches its sample on smpl_rdy and emits a 1-bit stream
// ones density tracks (s + 2^17) / 2^18

`timescale 1ns/1ps
`default_nettype none

module stereo_dac
    import synth_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     smpl_rdy,
    input  wire logic signed [smpl_w-1:0] smpl_l,
    input  wire logic signed [smpl_w-1:0] smpl_r,
    output logic                          dac_out_l,
    output logic                          dac_out_r
);

    // signed mid-scale offset, 2^17
    localparam logic [smpl_w-1:0] mid_scale = smpl_w'(1) << (smpl_w - 1);

    logic signed [smpl_w-1:0] smpl_in [2];
    logic [1:0]               dac_q;

    // channel 0 left, channel 1 right
    assign smpl_in[0] = smpl_l;
    assign smpl_in[1] = smpl_r;

    // ------------------------------------------------------------------
    // per channel modulator
    // ------------------------------------------------------------------
    for (genvar ch = 0; ch < 2; ch++) begin : g_mod
        logic signed [smpl_w-1:0] lat;
        logic [smpl_w-1:0]        off;
        // top bit holds the carry, which is the output bit
        logic [smpl_w:0]          acc;

        // offset binary
        assign off = $unsigned(lat) + mid_scale;

        always_ff @(posedge clk) begin
            if (rst) begin
                lat <= '0;
                acc <= '0;
            end else begin
                if (smpl_rdy) lat <= smpl_in[ch];
                acc <= {1'b0, acc[smpl_w-1:0]} + {1'b0, off};
            end
        end

        assign dac_q[ch] = acc[smpl_w];
    end

    assign dac_out_l = dac_q[0];
    assign dac_out_r = dac_q[1];

endmodule

`default_nettype wire

// File: pulse_gen.sv
// pulse_gen
// monophonic square wave voice, the execute stage of the synth
// holds note, velocity, gate and pan; steps the phase once per sample tick
// square amplitude follows velocity, split left and right by pan

`timescale 1ns/1ps
`default_nettype none

module pulse_gen
    import synth_pkg::*;
#(
    parameter int clk_freq  = 100_000_000,
    parameter int smpl_rate = 48000
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     midi_rdy,
    input  wire midi_cmd_e                midi_cmd,
    input  wire logic [6:0]               midi_data0,
    input  wire logic [6:0]               midi_data1,
    output logic                          smpl_rdy,
    output logic signed [smpl_w-1:0]      smpl_l,
    output logic signed [smpl_w-1:0]      smpl_r
);

    localparam int tick_div = clk_freq / smpl_rate;
    localparam int tick_w   = $clog2(tick_div);
    localparam logic [tick_w-1:0] tick_last = tick_w'(tick_div - 1);

    logic [tick_w-1:0]         tick_cnt;
    logic                      tick;

    // voice state
    logic [6:0]                note;
    logic [6:0]                vel;
    logic [6:0]                pan;
    logic                      gate;
    logic [phase_w-1:0]        phase;

    logic [3:0]                semi;
    logic [3:0]                oct;
    logic [phase_w-1:0]        eff_inc;
    logic [smpl_w-1:0]         amp;
    logic signed [smpl_w-1:0]  raw_wave;
    logic [7:0]                gain_l;
    logic [7:0]                gain_r;
    logic signed [smpl_w+7:0]  prod_l;
    logic signed [smpl_w+7:0]  prod_r;
    logic signed [smpl_w+7:0]  shr_l;
    logic signed [smpl_w+7:0]  shr_r;

    // sample rate tick, counted from reset release
    assign tick = (tick_cnt == tick_last);

    always_ff @(posedge clk) begin
        if (rst || tick) tick_cnt <= '0;
        else             tick_cnt <= tick_cnt + 1'b1;
    end

    // ------------------------------------------------------------------
    // pitch and gain
    // ------------------------------------------------------------------
    // semitone entry, shifted up by octave
    assign semi    = 4'(note % 7'd12);
    assign oct     = 4'(note / 7'd12);
    assign eff_inc = note_inc[semi] << oct;

    assign amp      = smpl_w'(vel) << amp_shift;
    assign raw_wave = !gate     ? '0 :
                      phase[phase_w-1] ? -$signed(amp) : $signed(amp);

    // pan 0 is hard left
    assign gain_l = 8'd127 - {1'b0, pan};
    assign gain_r = {1'b0, pan};
    assign prod_l = raw_wave * $signed(gain_l);
    assign prod_r = raw_wave * $signed(gain_r);
    assign shr_l  = prod_l >>> 7;
    assign shr_r  = prod_r >>> 7;

    // ------------------------------------------------------------------
    // voice state and sample output
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        smpl_rdy <= tick;
        if (rst) begin
            gate   <= 1'b0;
            note   <= 7'd0;
            vel    <= 7'd0;
            pan    <= pan_default;
            phase  <= '0;
            smpl_l <= '0;
            smpl_r <= '0;
        end else begin
            if (tick) begin
                smpl_l <= shr_l[smpl_w-1:0];
                smpl_r <= shr_r[smpl_w-1:0];
                if (gate) phase <= phase + eff_inc;
            end
            // a message wins over the tick in the same cycle
            if (midi_rdy) begin
                case (midi_cmd)
                    cmd_note_on: begin
                        note  <= midi_data0;
                        vel   <= midi_data1;
                        gate  <= 1'b1;
                        phase <= '0;
                    end
                    // release only the held note
                    cmd_note_off: if (midi_data0 == note) gate <= 1'b0;
                    cmd_ctrl:     if (midi_data0 == cc_pan) pan <= midi_data1;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: midi_decoder.sv
// midi_decoder
// parses the MIDI byte stream into command strobes for one channel
// keeps running status; realtime bytes pass through without effect
// note-on with velocity 0 comes out as note-off

`timescale 1ns/1ps
`default_nettype none

module midi_decoder
    import synth_pkg::*;
#(
    parameter logic [3:0] midi_ch = 4'd0
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       byte_strb,
    input  wire logic [7:0] byte_data,
    output logic            midi_rdy,
    output midi_cmd_e       midi_cmd,
    output logic [6:0]      midi_data0,
    output logic [6:0]      midi_data1
);

    // running status, zero when none is held
    logic [7:0] run_status;
    logic       have_d0;
    logic [6:0] data0_q;

    logic       one_byte;
    logic       msg_done;
    midi_cmd_e  cmd_next;
    logic [6:0] d0_next;
    logic [6:0] d1_next;

    // Cn and Dn carry one data byte, the rest two
    assign one_byte = (run_status[7:4] == 4'hc) || (run_status[7:4] == 4'hd);

    // data byte that closes a message
    assign msg_done = byte_strb && !byte_data[7] && run_status[7] && (one_byte || have_d0);

    // ------------------------------------------------------------------
    // command decode of the completing byte
    // ------------------------------------------------------------------
    always_comb begin
        d0_next = one_byte ? byte_data[6:0] : data0_q;
        d1_next = one_byte ? 7'd0 : byte_data[6:0];
        case (run_status[7:4])
            4'h8:    cmd_next = cmd_note_off;
            // zero velocity is a release
            4'h9:    cmd_next = (d1_next == 7'd0) ? cmd_note_off : cmd_note_on;
            4'hb:    cmd_next = cmd_ctrl;
            default: cmd_next = cmd_other;
        endcase
    end

    // ------------------------------------------------------------------
    // parse state
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        midi_rdy <= 1'b0;
        if (rst) begin
            run_status <= 8'h00;
            have_d0    <= 1'b0;
        end else if (byte_strb && byte_data < 8'hf8) begin
            if (byte_data[7]) begin
                // system common cancels running status
                run_status <= (byte_data < 8'hf0) ? byte_data : 8'h00;
                have_d0    <= 1'b0;
            end else if (msg_done) begin
                have_d0 <= 1'b0;
                // other channels still parse, just stay silent
                if (run_status[3:0] == midi_ch) begin
                    midi_rdy <= 1'b1;
                end
            end else if (run_status[7]) begin
                data0_q <= byte_data[6:0];
                have_d0 <= 1'b1;
            end
        end
    end

    // message payload, valid with midi_rdy
    always_ff @(posedge clk) begin
        if (msg_done) begin
            midi_cmd   <= cmd_next;
            midi_data0 <= d0_next;
            midi_data1 <= d1_next;
        end
    end

endmodule

`default_nettype wire

// File: uart_rx.sv
// uart_rx
// 8N1 serial receiver for the MIDI input
// start edge confirmed at half a bit, data sampled at bit centres, LSB first
// byte_strb pulses one cycle at the middle of a good stop bit

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int clk_freq  = 100_000_000,
    parameter int baud_rate = 38400
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       rx,
    output logic            byte_strb,
    output logic [7:0]      byte_data
);

    // clocks per bit and divider width
    localparam int bit_div = clk_freq / baud_rate;
    localparam int div_w   = $clog2(bit_div);
    localparam logic [div_w-1:0] div_last = div_w'(bit_div - 1);
    localparam logic [div_w-1:0] div_half = div_w'(bit_div / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

    state_e           state;
    logic [div_w-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             rx_meta;
    logic             rx_sync;

    // two-flop synchroniser, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        byte_strb <= 1'b0;
        if (rst) begin
            state   <= st_idle;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            case (state)
                st_idle: begin
                    div_cnt <= '0;
                    if (!rx_sync) state <= st_start;
                end
                // glitch check at the middle of the start bit
                st_start: if (div_cnt == div_half) begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= rx_sync ? st_idle : st_data;
                end
                st_data: if (div_cnt == div_last) begin
                    div_cnt   <= '0;
                    shift_reg <= {rx_sync, shift_reg[7:1]};
                    bit_cnt   <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= st_stop;
                end
                // low stop bit means framing error, frame dropped
                st_stop: if (div_cnt == div_last) begin
                    state <= st_idle;
                    if (rx_sync) begin
                        byte_strb <= 1'b1;
                        byte_data <= shift_reg;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: synth_pkg.sv
// synth_pkg
// shared widths, MIDI command codes and pitch table for the pulse synth
// pitch is a per-sample phase increment, octave zero, one entry per semitone

`default_nettype none

package synth_pkg;

    // sample words are signed two's complement
    localparam int smpl_w  = 18;
    localparam int phase_w = 24;

    // decoded MIDI command
    typedef enum logic [1:0] {
        cmd_note_off = 2'd0,
        cmd_note_on  = 2'd1,
        cmd_ctrl     = 2'd2,
        cmd_other    = 2'd3
    } midi_cmd_e;

    // octave zero increments, C to B
    // higher octaves shift left by note / 12
    localparam logic [phase_w-1:0] note_inc [12] = '{
        24'd5715, 24'd6055, 24'd6415, 24'd6796,
        24'd7200, 24'd7629, 24'd8082, 24'd8563,
        24'd9072, 24'd9611, 24'd10183, 24'd10788
    };

    // velocity to amplitude, peak 127 * 1024 = 130048
    localparam int amp_shift = 10;

    // pan controller
    localparam logic [6:0] cc_pan      = 7'd10;
    localparam logic [6:0] pan_default = 7'd64;

endpackage

`default_nettype wire
